// File: all.f
+incdir+.
arb_pkg.sv
frame_pkg.sv
chan_fifo.sv
mix_arbiter.sv
frame_checker.sv
mixer_top.sv
tb_mixer.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mixer \
  -f all.f -o vtb_mixer

status=0
output=$(./obj_dir/vtb_mixer 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb_mixer.sv
`default_nettype none
`timescale 1ns/100ps

`include "mixer_consts.svh"

module tb_mixer;

  import frame_pkg::*;
  import arb_pkg::*;

  localparam int DW = `MIX_DATA_WIDTH;
  localparam int IW = `MIX_ID_WIDTH;

  logic     CLK;
  logic     RESET;
  logic     wr_en0;
  logic     wr_en1;
  word_t    wr_data0;
  word_t    wr_data1;
  logic     ready;
  level_t   free0;
  level_t   free1;
  mix_out_t out;

  word_t exp_q [2][$];
  logic  end_q [2][$];
  word_t pkt_data [$];
  logic  pkt_hdr [$];
  logic  pkt_ftr [$];
  logic  at_start [2];
  logic  open_pkt [2];
  int    pend [2];
  logic  prev_valid;
  logic  quiet;
  logic  alt_check;
  int    alt_checks;
  chan_t burst_chan;
  chan_t last_served;
  word_t mon_word;
  logic  mon_end;

  mixer_top i_dut (
    .CLK      (CLK),
    .RESET    (RESET),
    .wr_en0   (wr_en0),
    .wr_data0 (wr_data0),
    .wr_en1   (wr_en1),
    .wr_data1 (wr_data1),
    .ready    (ready),
    .free0    (free0),
    .free1    (free1),
    .out      (out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input word_t got, input word_t want);
    if (got !== want) begin
      $display("error %0t ns: data %h, expected %h", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_chan(input chan_t got, input chan_t want);
    if (got !== want) begin
      $display("error %0t ns: channel %0d, expected %0d", $time, got, want);
      stop_run();
    end
  endtask

  task automatic check_level(input level_t got, input level_t want);
    if (got !== want) begin
      $display("error %0t ns: free space %0d, expected %0d", $time, got, want);
      stop_run();
    end
  endtask

  function automatic level_t room_of(input chan_t c);
    return (c == chan_t'(1)) ? free1 : free0;
  endfunction

  // random word whose id fields match no frame id.
  function automatic word_t body_word();
    word_t w;
    w = {$urandom, $urandom};
    if (w[DW-1 -: IW] == `MIX_HEADER_ID || w[DW-1 -: IW] == `MIX_ERR_HEADER_ID) begin
      w[DW-IW] = ~w[DW-IW];
    end
    if (w[IW-1:0] == `MIX_FOOTER_ID || w[IW-1:0] == `MIX_ERR_FOOTER_ID) begin
      w[0] = ~w[0];
    end
    return w;
  endfunction

  task automatic add_word(input word_t w, input logic hdr, input logic ftr);
    pkt_data.push_back(w);
    pkt_hdr.push_back(hdr);
    pkt_ftr.push_back(ftr);
  endtask

  task automatic add_packet(input logic with_hdr, input logic with_ftr);
    int    nb;
    word_t w;
    nb = $urandom_range(6, 0);
    if (with_hdr) begin
      w = body_word();
      w[DW-1 -: IW] = `MIX_HEADER_ID;
      add_word(w, 1'b1, 1'b0);
    end
    repeat (nb) add_word(body_word(), 1'b0, 1'b0);
    if (with_ftr) begin
      w = body_word();
      w[IW-1:0] = `MIX_FOOTER_ID;
      add_word(w, 1'b0, 1'b1);
    end
  endtask

  // kind 0 is normal, 1 header-less, 2 footer-less plus a normal packet.
  task automatic build_packet(input int kind);
    pkt_data.delete();
    pkt_hdr.delete();
    pkt_ftr.delete();
    case (kind)
      1: add_packet(1'b0, 1'b1);
      2: begin
        add_packet(1'b1, 1'b0);
        add_packet(1'b1, 1'b1);
      end
      default: add_packet(1'b1, 1'b1);
    endcase
  endtask

  task automatic model_push(input chan_t c, input word_t w, input logic hdr, input logic ftr);
    word_t e;
    word_t prev;
    logic  opens;
    e = w;
    opens = hdr;
    // a burst that opens without a header gets the error header id.
    if (at_start[c] && !hdr) begin
      e[DW-1 -: IW] = `MIX_ERR_HEADER_ID;
      opens = 1'b1;
    end
    // a header inside an open packet closes the word before it.
    if (hdr && open_pkt[c]) begin
      prev = exp_q[c].pop_back();
      prev[IW-1:0] = `MIX_ERR_FOOTER_ID;
      exp_q[c].push_back(prev);
    end
    exp_q[c].push_back(e);
    end_q[c].push_back(ftr);
    at_start[c] = ftr;
    if (ftr) begin
      open_pkt[c] = 1'b0;
      pend[c]++;
    end else if (opens) begin
      open_pkt[c] = 1'b1;
    end
  endtask

  task automatic send_packet(input chan_t c);
    for (int i = 0; i < pkt_data.size(); i++) begin
      @(posedge CLK);
      if (c == chan_t'(1)) begin
        wr_en1   <= 1'b1;
        wr_data1 <= pkt_data[i];
      end else begin
        wr_en0   <= 1'b1;
        wr_data0 <= pkt_data[i];
      end
      model_push(c, pkt_data[i], pkt_hdr[i], pkt_ftr[i]);
    end
    @(posedge CLK);
    wr_en0 <= 1'b0;
    wr_en1 <= 1'b0;
  endtask

  task automatic wait_room(input chan_t c, input int n);
    int t;
    t = 0;
    @(negedge CLK);
    while (int'(room_of(c)) < n) begin
      t++;
      if (t > 1000) begin
        $display("timed out waiting for room in channel %0d", c);
        stop_run();
      end
      @(negedge CLK);
    end
  endtask

  task automatic wait_idle();
    int t;
    int low;
    t = 0;
    low = 0;
    while (low < 6) begin
      @(negedge CLK);
      low = out.valid ? 0 : low + 1;
      t++;
      if (t > 200) begin
        $display("timed out waiting for the output to go idle");
        stop_run();
      end
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(negedge CLK);
      t++;
      if (t > 3000) begin
        $display("timed out waiting for queued packets to come out");
        stop_run();
      end
    end
  endtask

  always @(negedge CLK) begin
    if (!RESET && out.valid) begin
      if (quiet) begin
        $display("an output word appeared while ready was low");
        stop_run();
      end
      if (!prev_valid) begin
        // both channels waiting means the other one wins.
        if (alt_check && pend[0] > 0 && pend[1] > 0) begin
          check_chan(out.chan, ~last_served);
          alt_checks++;
        end
        burst_chan = out.chan;
        last_served = out.chan;
      end
      check_chan(out.chan, burst_chan);
      if (exp_q[out.chan].size() == 0) begin
        $display("channel %0d sent a word that no packet accounts for", out.chan);
        stop_run();
      end
      mon_word = exp_q[out.chan].pop_front();
      mon_end = end_q[out.chan].pop_front();
      check_word(out.data, mon_word);
      if (mon_end) begin
        pend[out.chan]--;
      end
    end
    prev_valid = !RESET && out.valid;
  end

  initial begin
    int    n;
    chan_t c;
    int    held [2];
    void'($urandom(25));
    RESET = 1'b1;
    wr_en0 = 1'b0;
    wr_en1 = 1'b0;
    wr_data0 = '0;
    wr_data1 = '0;
    ready = 1'b0;
    quiet = 1'b0;
    alt_check = 1'b0;
    alt_checks = 0;
    prev_valid = 1'b0;
    burst_chan = chan_t'(0);
    last_served = chan_t'(1);
    foreach (pend[i]) begin
      at_start[i] = 1'b1;
      open_pkt[i] = 1'b0;
      pend[i] = 0;
      held[i] = 0;
    end
    repeat (2) @(posedge CLK);
    RESET <= 1'b0;
    ready <= 1'b1;

    for (n = 0; n < 80; n++) begin
      c = chan_t'($urandom_range(1, 0));
      build_packet($urandom_range(2, 0));
      wait_room(c, pkt_data.size());
      send_packet(c);
    end
    wait_drain();

    // with ready low nothing may leave while both channels fill up.
    @(posedge CLK);
    ready <= 1'b0;
    wait_idle();
    quiet = 1'b1;
    for (n = 0; n < 6; n++) begin
      c = chan_t'(n % 2);
      build_packet($urandom_range(2, 0));
      @(negedge CLK);
      if (int'(room_of(c)) >= pkt_data.size()) begin
        send_packet(c);
        held[c] += pkt_data.size();
      end
    end
    repeat (100) @(posedge CLK);
    @(negedge CLK);
    // both buffers were empty, so free space drops by the words held.
    check_level(free0, level_t'(`MIX_FIFO_DEPTH - held[0]));
    check_level(free1, level_t'(`MIX_FIFO_DEPTH - held[1]));
    quiet = 1'b0;
    alt_check = 1'b1;
    @(posedge CLK);
    ready <= 1'b1;
    wait_drain();
    wait_idle();
    check_level(free0, level_t'(`MIX_FIFO_DEPTH));
    check_level(free1, level_t'(`MIX_FIFO_DEPTH));

    if (alt_checks == 0) begin
      $display("no burst was granted while both channels were waiting");
      stop_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mixer_top.sv
`default_nettype none
`timescale 1ns/100ps

module mixer_top (
  input  wire logic             CLK,
  input  wire logic             RESET,
  input  wire logic             wr_en0,
  input  wire frame_pkg::word_t wr_data0,
  input  wire logic             wr_en1,
  input  wire frame_pkg::word_t wr_data1,
  input  wire logic             ready,
  output frame_pkg::level_t     free0,
  output frame_pkg::level_t     free1,
  output frame_pkg::mix_out_t   out
);

  import frame_pkg::*;
  import arb_pkg::*;

  fifo_word_t head0;
  fifo_word_t head1;
  logic       read_request0;
  logic       read_request1;
  logic       pop0;
  logic       pop1;
  read_ctl_t  read_ctl;

  chan_fifo u_fifo0 (
    .CLK          (CLK),
    .RESET        (RESET),
    .wr_en        (wr_en0),
    .wr_data      (wr_data0),
    .pop          (pop0),
    .head         (head0),
    .read_request (read_request0),
    .free         (free0)
  );

  chan_fifo u_fifo1 (
    .CLK          (CLK),
    .RESET        (RESET),
    .wr_en        (wr_en1),
    .wr_data      (wr_data1),
    .pop          (pop1),
    .head         (head1),
    .read_request (read_request1),
    .free         (free1)
  );

  mix_arbiter u_arb (
    .CLK           (CLK),
    .RESET         (RESET),
    .read_request0 (read_request0),
    .read_request1 (read_request1),
    .head_footer0  (head0.is_footer),
    .head_footer1  (head1.is_footer),
    .ready         (ready),
    .pop0          (pop0),
    .pop1          (pop1),
    .read_ctl      (read_ctl)
  );

  frame_checker u_chk (
    .CLK      (CLK),
    .RESET    (RESET),
    .head0    (head0),
    .head1    (head1),
    .read_ctl (read_ctl),
    .out      (out)
  );

endmodule

`default_nettype wire

// File: frame_checker.sv
`default_nettype none
`timescale 1ns/100ps

`include "mixer_consts.svh"

module frame_checker (
  input  wire logic                  CLK,
  input  wire logic                  RESET,
  input  wire frame_pkg::fifo_word_t head0,
  input  wire frame_pkg::fifo_word_t head1,
  input  wire arb_pkg::read_ctl_t    read_ctl,
  output frame_pkg::mix_out_t        out
);

  import frame_pkg::*;
  import arb_pkg::*;

  localparam int DW = `MIX_DATA_WIDTH;
  localparam int IW = `MIX_ID_WIDTH;

  localparam frame_id_t ERR_HEADER_ID = `MIX_ERR_HEADER_ID;
  localparam frame_id_t ERR_FOOTER_ID = `MIX_ERR_FOOTER_ID;

  fifo_word_t sel;
  logic       hdr_lost;
  logic       ftr_lost;
  logic       in_hdr;
  word_t      in_data;
  logic       open_q;
  mix_out_t   s0;
  mix_out_t   s1;

  assign sel = (read_ctl.chan == chan_t'(1)) ? head1 : head0;

  // a burst must open with a header.
  assign hdr_lost = read_ctl.active && read_ctl.first && !sel.is_header;
  assign in_hdr   = sel.is_header || hdr_lost;
  assign in_data  = hdr_lost ? {ERR_HEADER_ID, sel.data[DW-IW-1:0]} : sel.data;

  // a header while a packet is open closes the word before it.
  assign ftr_lost = read_ctl.active && sel.is_header && open_q;

  // stage 0, select and header repair.
  always_ff @(posedge CLK) begin
    if (RESET) begin
      s0.valid <= 1'b0;
      open_q   <= 1'b0;
    end else begin
      s0.valid <= read_ctl.active;
      if (read_ctl.active) begin
        if (sel.is_footer) begin
          open_q <= 1'b0;
        end else if (in_hdr) begin
          open_q <= 1'b1;
        end
      end
    end
    s0.chan <= read_ctl.chan;
    s0.data <= in_data;
  end

  // stage 1, footer repair on the word that precedes a header.
  always_ff @(posedge CLK) begin
    if (RESET) begin
      s1.valid <= 1'b0;
    end else begin
      s1.valid <= s0.valid;
    end
    s1.chan <= s0.chan;
    if (ftr_lost) begin
      s1.data <= {s0.data[DW-1:IW], ERR_FOOTER_ID};
    end else begin
      s1.data <= s0.data;
    end
  end

  // stage 2, output register.
  always_ff @(posedge CLK) begin
    if (RESET) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= s1.valid;
    end
    out.chan <= s1.chan;
    out.data <= s1.data;
  end

  // back to back words after a footer start a new packet.
  a_hdr_after_ftr: assert property (
    @(posedge CLK) disable iff (RESET)
    (out.valid && has_footer_id(out.data)) ##1 out.valid |-> has_header_id(out.data)
  );

endmodule

`default_nettype wire

// File: mix_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module mix_arbiter (
  input  wire logic           CLK,
  input  wire logic           RESET,
  input  wire logic           read_request0,
  input  wire logic           read_request1,
  input  wire logic           head_footer0,
  input  wire logic           head_footer1,
  input  wire logic           ready,
  output logic                pop0,
  output logic                pop1,
  output arb_pkg::read_ctl_t  read_ctl
);

  import arb_pkg::*;

  arb_state_t state;
  chan_t      last_chan;
  chan_t      pick;
  logic       first_q;
  logic       cur_footer;

  // when both wait, serve the one not served last.
  always_comb begin
    if (read_request0 && read_request1) begin
      pick = ~last_chan;
    end else if (read_request1) begin
      pick = chan_t'(1);
    end else begin
      pick = chan_t'(0);
    end
  end

  // last_chan also names the channel of the running burst.
  assign cur_footer = (last_chan == chan_t'(1)) ? head_footer1 : head_footer0;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state     <= ARB_IDLE;
      last_chan <= chan_t'(1);
      first_q   <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          // ready only gates the start of a burst.
          if (ready && (read_request0 || read_request1)) begin
            state     <= ARB_READ;
            last_chan <= pick;
            first_q   <= 1'b1;
          end
        end
        ARB_READ: begin
          first_q <= 1'b0;
          if (cur_footer) begin
            state <= ARB_GAP;
          end
        end
        ARB_GAP: begin
          state <= ARB_IDLE;
        end
        default: begin
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  assign pop0 = (state == ARB_READ) && (last_chan == chan_t'(0));
  assign pop1 = (state == ARB_READ) && (last_chan == chan_t'(1));

  assign read_ctl = '{
    active: (state == ARB_READ),
    first:  first_q,
    chan:   last_chan
  };

  a_one_pop: assert property (
    @(posedge CLK) disable iff (RESET)
    !(pop0 && pop1)
  );

  // a burst never reads beyond the last footer stored in its buffer.
  a_pop_has_packet: assert property (
    @(posedge CLK) disable iff (RESET)
    (pop0 || pop1) |-> ((pop0 && read_request0) || (pop1 && read_request1))
  );

endmodule

`default_nettype wire

// File: chan_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "mixer_consts.svh"

module chan_fifo #(
  parameter int DEPTH = `MIX_FIFO_DEPTH
) (
  input  wire logic                CLK,
  input  wire logic                RESET,
  input  wire logic                wr_en,
  input  wire frame_pkg::word_t    wr_data,
  input  wire logic                pop,
  output frame_pkg::fifo_word_t    head,
  output logic                     read_request,
  output frame_pkg::level_t        free
);

  import frame_pkg::*;

  localparam int AW = $clog2(DEPTH);

  typedef logic [AW-1:0] ptr_t;
  typedef logic [AW:0] cnt_t;

  fifo_word_t mem [DEPTH];
  fifo_word_t wr_word;
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  cnt_t       count;
  cnt_t       foot_cnt;

  // classify once here so the read side only looks at flags.
  assign wr_word = '{
    data:      wr_data,
    is_header: has_header_id(wr_data),
    is_footer: has_footer_id(wr_data)
  };

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      foot_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      case ({wr_en, pop})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;
      endcase
      // one count per complete packet waiting.
      foot_cnt <= foot_cnt + cnt_t'(wr_en && wr_word.is_footer)
                           - cnt_t'(pop && head.is_footer);
    end
  end

  // head is shown ahead of the pop.
  assign head         = mem[rd_ptr];
  assign read_request = (foot_cnt != '0);
  assign free         = level_t'(DEPTH - int'(count));

  a_no_pop_empty: assert property (
    @(posedge CLK) disable iff (RESET)
    pop |-> (count != '0)
  );

  a_no_write_full: assert property (
    @(posedge CLK) disable iff (RESET)
    wr_en |-> (count != cnt_t'(DEPTH))
  );

endmodule

`default_nettype wire

// File: frame_pkg.sv
`default_nettype none

`include "mixer_consts.svh"

package frame_pkg;

  typedef logic [`MIX_DATA_WIDTH-1:0] word_t;
  typedef logic [`MIX_ID_WIDTH-1:0] frame_id_t;
  typedef logic [`MIX_LEVEL_WIDTH-1:0] level_t;

  // flags are filled when the word enters a channel buffer.
  typedef struct packed {
    word_t data;
    logic  is_header;
    logic  is_footer;
  } fifo_word_t;

  typedef struct packed {
    logic           valid;
    arb_pkg::chan_t chan;
    word_t          data;
  } mix_out_t;

  function automatic logic has_header_id(word_t w);
    frame_id_t id;
    id = w[`MIX_DATA_WIDTH-1 -: `MIX_ID_WIDTH];
    return (id == `MIX_HEADER_ID) || (id == `MIX_ERR_HEADER_ID);
  endfunction

  function automatic logic has_footer_id(word_t w);
    frame_id_t id;
    id = w[`MIX_ID_WIDTH-1:0];
    return (id == `MIX_FOOTER_ID) || (id == `MIX_ERR_FOOTER_ID);
  endfunction

endpackage

`default_nettype wire

// File: arb_pkg.sv
`default_nettype none

package arb_pkg;

  typedef logic [0:0] chan_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_GAP
  } arb_state_t;

  typedef struct packed {
    logic  active;
    logic  first;
    chan_t chan;
  } read_ctl_t;

endpackage

`default_nettype wire

// File: mixer_consts.svh
`ifndef MIXER_CONSTS_SVH
`define MIXER_CONSTS_SVH

// word and id field widths.
`define MIX_DATA_WIDTH 64
`define MIX_ID_WIDTH 16

// header ids live in the top field of a word.
`define MIX_HEADER_ID 16'hAAAA
`define MIX_ERR_HEADER_ID 16'hAAEE

// footer ids live in the low field of a word.
`define MIX_FOOTER_ID 16'h5555
`define MIX_ERR_FOOTER_ID 16'h55EE

// channel buffer depth in words.
`define MIX_FIFO_DEPTH 16

// free-space count, wide enough for 0 to 16.
`define MIX_LEVEL_WIDTH 5

`endif
